/* src.f */
+incdir+verilog
+incdir+tb
verilog/vc_sel_pkg.sv
verilog/carry_sum_gen.sv
verilog/parallel_counter_15.sv
verilog/request_counter.sv
verilog/min_occupancy_finder.sv
verilog/vc_select_combine.sv
verilog/vc_select_unit.sv
tb/tb_vc_select_unit.sv

/* run_sim.sh */
#!/bin/sh
# Builds the VC selector testbench with Verilator and runs it.
# Exits 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f \
    --top-module tb_vc_select_unit \
    -Mdir obj_dir -o sim_vc_select
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_vc_select 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi

/* tb/vc_select_tasks.svh */
`ifndef VC_SELECT_TASKS_SVH
`define VC_SELECT_TASKS_SVH

localparam int RANDOM_MASKS = 20;
localparam int RANDOM_TIES  = 10;
localparam logic [9:0] GAP_PATTERN = 10'b1011001101; // bit 0 driven first

// steps per test, two flush steps each except the idle test
localparam int LEN_IDLE    = 6;
localparam int LEN_COUNT   = 1 + `VS_REQ_WIDTH + 1 + RANDOM_MASKS + 2;
localparam int LEN_MIN     = `VS_NUM_VC + 4 + RANDOM_TIES + 2;
localparam int LEN_GRANT   = 5 + 2;
localparam int LEN_PIPE    = 10 + 10 + 2;
localparam int TOTAL_STEPS = LEN_IDLE + LEN_COUNT + LEN_MIN + LEN_GRANT + LEN_PIPE;

// reference model
function automatic req_count_t count_ones(input req_mask_t m);
    req_count_t c;
    c = '0;
    for (int i = 0; i < `VS_REQ_WIDTH; i++) begin
        if (m[i]) begin
            c = c + req_count_t'(1);
        end
    end
    return c;
endfunction

function automatic vc_idx_t lowest_min_index(input occ_array_t o);
    vc_idx_t best;
    best = '0;
    for (int i = 1; i < `VS_NUM_VC; i++) begin
        if (o[i] < o[best]) begin // strict, earlier channel keeps ties
            best = vc_idx_t'(i);
        end
    end
    return best;
endfunction

function automatic req_mask_t random_mask();
    return req_mask_t'($random(seed));
endfunction

function automatic occ_array_t random_occ(input int lo, input int span);
    occ_array_t o;
    for (int i = 0; i < `VS_NUM_VC; i++) begin
        o[i] = occ_t'(lo + int'($unsigned($random(seed)) % span));
    end
    return o;
endfunction

function automatic occ_array_t fill_occ(input int value);
    occ_array_t o;
    for (int i = 0; i < `VS_NUM_VC; i++) begin
        o[i] = occ_t'(value);
    end
    return o;
endfunction

task automatic report_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] want);
    $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
    abort_run();
endtask

// outputs now belong to the word driven two steps back
task automatic check_outputs();
    int   idx;
    logic v_exp;
    idx   = n_steps - 3;
    v_exp = (idx >= 0) ? exp_valid[idx] : 1'b0;
    assert (out_valid === v_exp)
        else report_mismatch("out_valid", 32'(out_valid), 32'(v_exp));
    if (v_exp) begin // data is only defined with out_valid
        assert (req_count === exp_count[idx])
            else report_mismatch("req_count", 32'(req_count), 32'(exp_count[idx]));
        assert (single_req === exp_single[idx])
            else report_mismatch("single_req", 32'(single_req), 32'(exp_single[idx]));
        assert (min_vc === exp_vc[idx])
            else report_mismatch("min_vc", 32'(min_vc), 32'(exp_vc[idx]));
        assert (min_occ === exp_occ[idx])
            else report_mismatch("min_occ", 32'(min_occ), 32'(exp_occ[idx]));
        assert (grant_valid === exp_grant[idx])
            else report_mismatch("grant_valid", 32'(grant_valid), 32'(exp_grant[idx]));
    end
endtask

// one clock step, drive on the rising edge and check on the falling one
task automatic drive_word(input logic v, input req_mask_t r, input occ_array_t o);
    req_count_t c;
    vc_idx_t    k;
    @(posedge clk);
    in_valid <= v;
    req      <= r;
    occ      <= o;
    c = count_ones(r);
    k = lowest_min_index(o);
    exp_valid[n_steps]  = v;
    exp_count[n_steps]  = c;
    exp_single[n_steps] = int'(c) <= 1;
    exp_vc[n_steps]     = k;
    exp_occ[n_steps]    = o[k];
    exp_grant[n_steps]  = (c != '0) && (int'(o[k]) < `VS_VC_DEPTH);
    n_steps++;
    @(negedge clk);
    check_outputs();
endtask

task automatic flush_pipeline();
    drive_word(1'b0, '0, '0);
    drive_word(1'b0, '0, '0);
endtask

task automatic test_reset_idle();
    for (int i = 0; i < LEN_IDLE; i++) begin
        drive_word(1'b0, random_mask(), random_occ(0, 17)); // data must be ignored
    end
endtask

task automatic test_request_count();
    req_mask_t m;
    drive_word(1'b1, '0, random_occ(0, 17));
    for (int i = 0; i < `VS_REQ_WIDTH; i++) begin
        m    = '0;
        m[i] = 1'b1;
        drive_word(1'b1, m, random_occ(0, 17));
    end
    drive_word(1'b1, '1, random_occ(0, 17));
    for (int i = 0; i < RANDOM_MASKS; i++) begin
        drive_word(1'b1, random_mask(), random_occ(0, 17));
    end
    flush_pipeline();
endtask

task automatic test_min_select();
    occ_array_t o;
    for (int k = 0; k < `VS_NUM_VC; k++) begin
        o    = random_occ(8, 9); // others in 8..16
        o[k] = occ_t'(k);        // single strict minimum
        drive_word(1'b1, random_mask(), o);
    end
    drive_word(1'b1, random_mask(), fill_occ(6)); // all tied, channel 0
    o    = fill_occ(11);
    o[5] = occ_t'(2);
    o[2] = occ_t'(2);
    drive_word(1'b1, random_mask(), o);
    o    = fill_occ(9);
    o[7] = occ_t'(1);
    o[6] = occ_t'(1);
    drive_word(1'b1, random_mask(), o);
    o    = fill_occ(12);
    o[0] = occ_t'(3);
    o[4] = occ_t'(3);
    o[7] = occ_t'(3);
    drive_word(1'b1, random_mask(), o);
    for (int i = 0; i < RANDOM_TIES; i++) begin
        drive_word(1'b1, random_mask(), random_occ(0, 3)); // narrow range, many ties
    end
    flush_pipeline();
endtask

task automatic test_grant_rule();
    occ_array_t o;
    drive_word(1'b1, random_mask() | req_mask_t'(1), fill_occ(`VS_VC_DEPTH));
    drive_word(1'b1, '0, random_occ(0, 10)); // free channels, no requester
    o    = fill_occ(`VS_VC_DEPTH);
    o[3] = occ_t'(9);
    drive_word(1'b1, random_mask() | req_mask_t'(1), o);
    o    = fill_occ(`VS_VC_DEPTH);
    o[7] = occ_t'(`VS_VC_DEPTH - 1); // one slot left
    drive_word(1'b1, req_mask_t'(1) << 14, o);
    drive_word(1'b1, '0, fill_occ(`VS_VC_DEPTH));
    flush_pipeline();
endtask

task automatic test_pipeline();
    for (int i = 0; i < 10; i++) begin
        drive_word(1'b1, random_mask(), random_occ(0, 17)); // back to back
    end
    for (int i = 0; i < 10; i++) begin
        drive_word(GAP_PATTERN[i], random_mask(), random_occ(0, 17));
    end
    flush_pipeline();
endtask

`endif

/* tb/tb_vc_select_unit.sv */
`timescale 1ns/100ps
`include "vc_sel_settings.svh"

module tb_vc_select_unit import vc_sel_pkg::*; ();

    logic       clk;
    logic       rst;
    logic       in_valid;
    req_mask_t  req;
    occ_array_t occ;
    logic       out_valid;
    req_count_t req_count;
    logic       single_req;
    vc_idx_t    min_vc;
    occ_t       min_occ;
    logic       grant_valid;

    int seed;    // shared by all random draws
    int n_steps; // words driven so far, idle ones included
    int cycles;

    // expected results, indexed by the step that drove the word
    logic       exp_valid  [256];
    req_count_t exp_count  [256];
    logic       exp_single [256];
    vc_idx_t    exp_vc     [256];
    occ_t       exp_occ    [256];
    logic       exp_grant  [256];

    `include "vc_select_tasks.svh"

    localparam int CYCLE_LIMIT = 2 * TOTAL_STEPS + 50;

    vc_select_unit i_vc_select_unit (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .req         (req),
        .occ         (occ),
        .out_valid   (out_valid),
        .req_count   (req_count),
        .single_req  (single_req),
        .min_vc      (min_vc),
        .min_occ     (min_occ),
        .grant_valid (grant_valid)
    );

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // guards against a stuck test
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
                abort_run();
            end
        end
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        seed     = 32'h6128;
        n_steps  = 0;
        rst      = 1'b1;
        in_valid = 1'b0;
        req      = '0;
        occ      = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        test_reset_idle();
        test_request_count();
        test_min_select();
        test_grant_rule();
        test_pipeline();

        $display("Test OK");
        $finish;
    end

endmodule

/* verilog/vc_select_unit.sv */
`timescale 1ns/100ps

module vc_select_unit import vc_sel_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  req_mask_t  req,
    input  occ_array_t occ,
    output logic       out_valid,
    output req_count_t req_count,
    output logic       single_req,
    output vc_idx_t    min_vc,
    output occ_t       min_occ,
    output logic       grant_valid
);

    logic       s1_valid;  // stage-one valid
    req_count_t s1_count;
    vc_onehot_t s1_onehot;
    occ_array_t s1_occ;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // stage one, both halves sample on the same edge
    request_counter i_request_counter (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .count (s1_count)
    );

    min_occupancy_finder i_min_occupancy_finder (
        .clk        (clk),
        .rst        (rst),
        .occ        (occ),
        .min_onehot (s1_onehot),
        .occ_q      (s1_occ)
    );

    // stage two
    vc_select_combine i_vc_select_combine (
        .clk         (clk),
        .rst         (rst),
        .valid       (s1_valid),
        .count       (s1_count),
        .min_onehot  (s1_onehot),
        .occ_q       (s1_occ),
        .out_valid   (out_valid),
        .req_count   (req_count),
        .single_req  (single_req),
        .min_vc      (min_vc),
        .min_occ     (min_occ),
        .grant_valid (grant_valid)
    );

endmodule

/* verilog/vc_select_combine.sv */
`timescale 1ns/100ps
`include "vc_sel_settings.svh"

module vc_select_combine import vc_sel_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       valid,
    input  req_count_t count,
    input  vc_onehot_t min_onehot,
    input  occ_array_t occ_q,
    output logic       out_valid,
    output req_count_t req_count,
    output logic       single_req,
    output vc_idx_t    min_vc,
    output occ_t       min_occ,
    output logic       grant_valid
);

    localparam occ_t full_occ = occ_t'(`VS_VC_DEPTH);

    vc_idx_t min_vc_d;
    occ_t    min_occ_d;
    logic    single_d;
    logic    grant_d;

    // one-hot to binary and occupancy pick as AND-OR trees
    always_comb begin
        min_vc_d  = '0;
        min_occ_d = '0;
        for (int i = 0; i < `VS_NUM_VC; i++) begin
            min_vc_d  = min_vc_d | (vc_idx_t'(i) & {$bits(vc_idx_t){min_onehot[i]}});
            min_occ_d = min_occ_d | (occ_q[i] & {`VS_OCC_WIDTH{min_onehot[i]}});
        end
    end

    assign single_d = count <= req_count_t'(1); // zero or one requester
    assign grant_d  = (count != '0) && (min_occ_d < full_occ);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin // hold last result on idle cycles
            req_count   <= count;
            single_req  <= single_d;
            min_vc      <= min_vc_d;
            min_occ     <= min_occ_d;
            grant_valid <= grant_d;
        end
    end

    // a grant must never point at a full channel
    a_grant_free: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && grant_valid |-> $past(occ_q[min_vc_d]) < full_occ
    ) else $error("grant on full channel %0d, occupancy %0d", min_vc, min_occ);

endmodule

/* verilog/min_occupancy_finder.sv */
`timescale 1ns/100ps
`include "vc_sel_settings.svh"

module min_occupancy_finder import vc_sel_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  occ_array_t occ,
    output vc_onehot_t min_onehot,
    output occ_array_t occ_q
);

    // row i holds channel i against every other channel
    logic [`VS_NUM_VC-2:0] cmp [`VS_NUM_VC];
    vc_onehot_t            min_d;

    generate
        for (genvar i = 0; i < `VS_NUM_VC; i++) begin : g_row
            for (genvar j = 0; j < `VS_NUM_VC-1; j++) begin : g_col
                if (i > j) begin : g_lower
                    // column j is channel j
                    assign cmp[i][j] = occ[i] < occ[j]; // strict so higher index loses ties
                end else begin : g_cmp
                    // column j is channel j+1
                    assign cmp[i][j] = occ[i] <= occ[j+1]; // lower index wins ties
                end
            end
            assign min_d[i] = &cmp[i]; // beats or ties all others
        end
    endgenerate

    always_ff @(posedge clk) begin
        min_onehot <= min_d;
        occ_q      <= occ; // kept aligned with the selection
    end

    // tie breaking must leave exactly one channel marked
    a_min_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot(min_onehot)
    ) else $error("minimum selection not one-hot: %b", min_onehot);

endmodule

/* verilog/request_counter.sv */
`timescale 1ns/100ps

module request_counter import vc_sel_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  req_mask_t  req,
    output req_count_t count
);

    req_count_t count_d; // combinational popcount

    parallel_counter_15 i_parallel_counter_15 (
        .in  (req),
        .out (count_d)
    );

    always_ff @(posedge clk) begin
        count <= count_d;
    end

    // the carry-sum tree must agree with a plain bit count of the previous mask
    a_count_match: assert property (
        @(posedge clk) disable iff (rst)
        count == req_count_t'($countones($past(req)))
    ) else $error("request count %0d does not match the previous mask", count);

endmodule

/* verilog/parallel_counter_15.sv */
`timescale 1ns/100ps

module parallel_counter_15 import vc_sel_pkg::*; (
    input  req_mask_t  in,
    output req_count_t out
);

    logic [2:0] abc_lo;
    logic [2:0] abc_hi;
    logic [2:0] abc_top;
    logic       s_lo;
    logic       s_hi;
    logic       s_top;
    logic [1:0] bit0_sum;  // top input plus both sum bits
    logic       spill;     // weight two, joins the carries
    logic [1:0] carry_cnt; // weight four

    carry_sum_gen i_cs_lo (
        .in  (in[6:0]),
        .abc (abc_lo),
        .s   (s_lo)
    );

    carry_sum_gen i_cs_hi (
        .in  (in[13:7]),
        .abc (abc_hi),
        .s   (s_hi)
    );

    assign bit0_sum = 2'(in[14]) + 2'(s_lo) + 2'(s_hi);
    assign spill    = bit0_sum[1];

    // six carries and the spill all carry weight two
    carry_sum_gen i_cs_top (
        .in  ({abc_hi, abc_lo, spill}),
        .abc (abc_top),
        .s   (s_top)
    );

    assign carry_cnt = 2'(abc_top[0]) + 2'(abc_top[1]) + 2'(abc_top[2]);

    assign out = {carry_cnt, s_top, bit0_sum[0]};

endmodule

/* verilog/carry_sum_gen.sv */
`timescale 1ns/100ps

module carry_sum_gen (
    input  logic [6:0] in,
    output logic [2:0] abc,
    output logic       s
);

    logic [3:0] grp_lo; // four-bit group
    logic [2:0] grp_hi; // three-bit group
    logic [2:0] cnt_lo; // 0..4
    logic [1:0] cnt_hi; // 0..3

    assign {grp_hi, grp_lo} = in;

    assign cnt_lo = 3'(grp_lo[0]) + 3'(grp_lo[1]) + 3'(grp_lo[2]) + 3'(grp_lo[3]);
    assign cnt_hi = 2'(grp_hi[0]) + 2'(grp_hi[1]) + 2'(grp_hi[2]);

    // s has weight one, each of a, b, c weight two
    assign s      = cnt_lo[0] ^ cnt_hi[0]; // parity of all seven inputs
    assign abc[2] = cnt_lo > 3'd1;         // pair in low group
    assign abc[1] = cnt_hi > 2'd1;         // pair in high group
    assign abc[0] = (cnt_lo == 3'd4) |     // second pair in low group
                    (cnt_lo[0] & cnt_hi[0]); // two odd leftovers

endmodule

/* verilog/vc_sel_pkg.sv */
`include "vc_sel_settings.svh"

package vc_sel_pkg;

    // request mask and its population count
    typedef logic [`VS_REQ_WIDTH-1:0]          req_mask_t;
    typedef logic [$clog2(`VS_REQ_WIDTH+1)-1:0] req_count_t; // 0..15

    // buffer occupancy of one channel, and all of them
    typedef logic [`VS_OCC_WIDTH-1:0]  occ_t;
    typedef occ_t [`VS_NUM_VC-1:0]     occ_array_t; // entry 0 is channel 0

    // channel selection, one-hot and encoded
    typedef logic [`VS_NUM_VC-1:0]         vc_onehot_t;
    typedef logic [$clog2(`VS_NUM_VC)-1:0] vc_idx_t;

endpackage

/* verilog/vc_sel_settings.svh */
`ifndef VC_SEL_SETTINGS_SVH
`define VC_SEL_SETTINGS_SVH

// request side
`define VS_REQ_WIDTH 15 // pending requesters per word

// virtual channel side
`define VS_NUM_VC    8  // channels compared per word
`define VS_OCC_WIDTH 5  // wide enough to hold VS_VC_DEPTH itself

// a channel reporting this occupancy has no free slot
`define VS_VC_DEPTH  16 // flits per channel buffer

`endif
